// File: Makefile
# Verilator build and run of the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= convEngineTb
FILELIST  ?= convEngine.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The log decides pass or fail, not the simulator exit status
run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: clockGen.sv
////////////////////////////////////////////////////////////////////////////
// clockGen: testbench clock with a 40 ns period and a power-on reset
// held low for the first two rising edges
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clockGen (
    output logic Clk,
    output logic arstN
);

    initial begin
        Clk = 1'b0;
        forever begin
            #20 Clk = ~Clk;
        end
    end

    // Released just after the second edge
    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge Clk);
        #2;
        arstN = 1'b1;
    end

endmodule

// File: convEngine.f
convPkg.sv
laneIf.sv
operandLoader.sv
seqMultiplier.sv
productReducer.sv
convEngine.sv
clockGen.sv
convEngine_asserts.sv
convEngineTb.sv

// File: convEngine.sv
////////////////////////////////////////////////////////////////////////////
// convEngine top level: operand loader, nine sequential multiplier
// lanes and the product reducer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module convEngine (
    input  logic                                                Clk,
    input  logic                                                arstN,
    input  logic                                                start,
    input  convPkg::laneMaskT                                   laneMask,
    input  logic [convPkg::laneCount*convPkg::dataWidth-1:0]    opA,
    input  logic [convPkg::laneCount*convPkg::dataWidth-1:0]    opB,
    input  logic                                                cfgWrite,
    input  convPkg::xbarAddrT                                   cfgAddr,
    input  logic                                                direct,
    output logic                                                busy,
    output convPkg::sumT                                        result,
    output logic                                                resultValid
);

    convPkg::dataT opAArr [convPkg::laneCount];
    convPkg::dataT opBArr [convPkg::laneCount];
    convPkg::laneMaskT activeMask;
    logic opDone;

    laneIf laneBus [convPkg::laneCount] ();

    // Lane n takes operand bits n*dataWidth and up
    for (genvar i = 0; i < convPkg::laneCount; i++) begin : genLane
        assign opAArr[i] = opA[i*convPkg::dataWidth +: convPkg::dataWidth];
        assign opBArr[i] = opB[i*convPkg::dataWidth +: convPkg::dataWidth];

        seqMultiplier mult_i (
            .Clk   (Clk),
            .arstN (arstN),
            .lane  (laneBus[i])
        );
    end

    operandLoader loader_i (
        .Clk        (Clk),
        .arstN      (arstN),
        .start      (start),
        .laneMask   (laneMask),
        .opA        (opAArr),
        .opB        (opBArr),
        .lanes      (laneBus),
        .activeMask (activeMask),
        .busy       (busy),
        .opDone     (opDone)
    );

    productReducer reducer_i (
        .Clk         (Clk),
        .arstN       (arstN),
        .lanes       (laneBus),
        .activeMask  (activeMask),
        .cfgWrite    (cfgWrite),
        .cfgAddr     (cfgAddr),
        .direct      (direct),
        .result      (result),
        .resultValid (resultValid),
        .opDone      (opDone)
    );

endmodule

// File: convEngineTb.sv
////////////////////////////////////////////////////////////////////////////
// convEngineTb: LFSR stimulus, reference dot product over a mirrored
// routing table, result compare process and per-test reporting
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module convEngineTb;

    typedef logic [convPkg::laneCount*convPkg::dataWidth-1:0] operandsT;

    logic Clk;
    logic genRstN;
    logic tbRstN;
    logic arstN;
    logic start;
    convPkg::laneMaskT laneMask;
    operandsT opA;
    operandsT opB;
    logic cfgWrite;
    convPkg::xbarAddrT cfgAddr;
    logic direct;
    logic busy;
    convPkg::sumT result;
    logic resultValid;

    logic [31:0] lfsrState;
    int routeMirror [convPkg::laneCount];
    logic [31:0] expSums [$];
    int expEdges [$];
    int cycleCount;
    int issuedCount;
    int checkedCount;
    int checkCount;
    int errorCount;

    // Power-on reset from the generator and mid-run reset from the stimulus
    assign arstN = genRstN & tbRstN;

    clockGen clk_i (
        .Clk   (Clk),
        .arstN (genRstN)
    );

    convEngine convEngine_i (.*);

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits[i] = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (bits[i]) begin
                lfsrState = lfsrState ^ 32'h8020_0003;
            end
        end
        return bits;
    endfunction

    function automatic operandsT randomOperands();
        operandsT flat;
        for (int i = 0; i < convPkg::laneCount; i++) begin
            flat[i*convPkg::dataWidth +: convPkg::dataWidth] =
                convPkg::dataT'(takeBits(convPkg::dataWidth));
        end
        return flat;
    endfunction

    // Sum over crossbar outputs of the product of the lane each output selects
    function automatic logic [31:0] refSum(input operandsT aFlat, input operandsT bFlat,
                                           input convPkg::laneMaskT mask, input logic useDirect);
        logic [31:0] acc;
        int srcLane;
        longint prod;
        acc = '0;
        for (int o = 0; o < convPkg::laneCount; o++) begin
            srcLane = useDirect ? o : routeMirror[o];
            if (mask[srcLane]) begin
                prod = longint'(convPkg::dataT'(aFlat[srcLane*convPkg::dataWidth +: 16]))
                     * longint'(convPkg::dataT'(bFlat[srcLane*convPkg::dataWidth +: 16]));
                acc = acc + prod[31:0];
            end
        end
        return acc;
    endfunction

    function automatic void resetMirror();
        for (int o = 0; o < convPkg::laneCount; o++) begin
            routeMirror[o] = o;
        end
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what,
                 $signed(got), $signed(expected));
        errorCount++;
    endtask

    task automatic abortRun(input string why);
        errorCount++;
        $display("TIMEOUT at %0t: %s", $time, why);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic endTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic issueOperation(input operandsT aFlat, input operandsT bFlat,
                                  input convPkg::laneMaskT mask, input logic useDirect);
        @(posedge Clk);
        #2;
        opA = aFlat;
        opB = bFlat;
        laneMask = mask;
        direct = useDirect;
        start = 1'b1;
        expSums.push_back(refSum(aFlat, bFlat, mask, useDirect));
        expEdges.push_back(cycleCount + 1);
        issuedCount++;
        @(posedge Clk);
        #2;
        start = 1'b0;
    endtask

    task automatic waitForResult();
        int waited;
        waited = 0;
        while (checkedCount != issuedCount && waited < 40) begin
            @(posedge Clk);
            waited++;
        end
        if (checkedCount != issuedCount) begin
            abortRun("no resultValid within 40 cycles of the start");
        end
    endtask

    task automatic runRandom(input convPkg::laneMaskT mask, input logic useDirect);
        operandsT aFlat;
        operandsT bFlat;
        aFlat = randomOperands();
        bFlat = randomOperands();
        issueOperation(aFlat, bFlat, mask, useDirect);
        waitForResult();
    endtask

    task automatic writeRoute(input int addr);
        @(posedge Clk);
        #2;
        cfgWrite = 1'b1;
        cfgAddr = convPkg::xbarAddrT'(addr);
        // Addresses past the last crosspoint are dropped
        if (addr < convPkg::laneCount * convPkg::laneCount) begin
            routeMirror[addr / convPkg::laneCount] = addr % convPkg::laneCount;
        end
        @(posedge Clk);
        #2;
        cfgWrite = 1'b0;
    endtask

    // Compare process samples outputs mid-cycle
    initial begin : compare
        logic [31:0] expected;
        int startEdge;
        forever begin
            @(negedge Clk);
            if (resultValid) begin
                if (expSums.size() == 0) begin
                    $display("ERROR at %0t: resultValid with no operation pending", $time);
                    errorCount++;
                end else begin
                    expected = expSums.pop_front();
                    startEdge = expEdges.pop_front();
                    checkCount += 3;
                    if (cycleCount - startEdge != 20) begin
                        reportMismatch("result latency", cycleCount - startEdge, 20);
                    end
                    // busy covers the result cycle too
                    if (busy !== 1'b1) begin
                        reportMismatch("busy at resultValid", busy, 32'd1);
                    end
                    if (result !== expected) begin
                        reportMismatch("result", result, expected);
                    end
                    checkedCount++;
                end
            end
        end
    end

    initial begin : stimulus
        int errorsBefore;
        int waited;
        operandsT aFlat;
        operandsT bFlat;
        logic [31:0] heldResult;
        start = 1'b0;
        laneMask = '0;
        opA = '0;
        opB = '0;
        cfgWrite = 1'b0;
        cfgAddr = '0;
        direct = 1'b0;
        tbRstN = 1'b1;
        lfsrState = 32'h2e0f_6a54;
        resetMirror();
        waited = 0;
        while (arstN !== 1'b1 && waited < 10) begin
            @(posedge Clk);
            waited++;
        end
        if (arstN !== 1'b1) begin
            abortRun("power-on reset never released");
        end

        errorsBefore = errorCount;
        repeat (20) runRandom('1, 1'b1);
        endTest("direct mode", errorsBefore);

        errorsBefore = errorCount;
        runRandom('0, 1'b0);
        checkCount++;
        if (result !== 32'd0) begin
            reportMismatch("result with no lanes", result, 32'd0);
        end
        for (int i = 0; i < convPkg::laneCount; i += 4) begin
            runRandom(convPkg::laneMaskT'(1) << i, 1'b0);
        end
        repeat (10) runRandom(convPkg::laneMaskT'(takeBits(convPkg::laneCount)), 1'b0);
        endTest("lane mask", errorsBefore);

        errorsBefore = errorCount;
        repeat (6) begin
            writeRoute(int'(takeBits(7)));
            runRandom(convPkg::laneMaskT'(takeBits(convPkg::laneCount)), 1'b0);
        end
        // Lane 4 on outputs 0 to 2, lane 7 on output 5
        writeRoute(0 * 9 + 4);
        writeRoute(1 * 9 + 4);
        writeRoute(2 * 9 + 4);
        writeRoute(5 * 9 + 7);
        aFlat = randomOperands();
        bFlat = randomOperands();
        issueOperation(aFlat, bFlat, '1, 1'b0);
        waitForResult();
        issueOperation(aFlat, bFlat, '1, 1'b1);
        waitForResult();
        writeRoute(81);
        writeRoute(100);
        writeRoute(127);
        issueOperation(aFlat, bFlat, '1, 1'b0);
        waitForResult();
        endTest("custom routing", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < 4; i++) begin
            aFlat = {convPkg::laneCount{i[0] ? 16'h7fff : 16'h8000}};
            bFlat = {convPkg::laneCount{i[1] ? 16'h7fff : 16'h8000}};
            issueOperation(aFlat, bFlat, '1, 1'b1);
            waitForResult();
        end
        endTest("extremes", errorsBefore);

        errorsBefore = errorCount;
        aFlat = randomOperands();
        bFlat = randomOperands();
        heldResult = refSum(aFlat, bFlat, '1, 1'b1);
        issueOperation(aFlat, bFlat, '1, 1'b1);
        repeat (5) @(posedge Clk);
        #2;
        opA = randomOperands();
        opB = randomOperands();
        start = 1'b1;
        @(posedge Clk);
        #2;
        start = 1'b0;
        waitForResult();
        // An extra resultValid would show up in the compare process
        repeat (30) @(posedge Clk);
        #2;
        checkCount++;
        if (result !== heldResult) begin
            reportMismatch("held result", result, heldResult);
        end
        issueOperation(randomOperands(), randomOperands(), '1, 1'b0);
        repeat (8) @(posedge Clk);
        #2;
        // Aborted operation never reports
        expSums.delete();
        expEdges.delete();
        checkedCount = issuedCount;
        tbRstN = 1'b0;
        @(negedge Clk);
        checkCount += 2;
        if (busy !== 1'b0 || resultValid !== 1'b0) begin
            $display("CHECK FAILED at %0t: busy or resultValid high during reset", $time);
            errorCount++;
        end
        if (result !== 32'd0) begin
            reportMismatch("result in reset", result, 32'd0);
        end
        @(posedge Clk);
        #2;
        tbRstN = 1'b1;
        resetMirror();
        runRandom('1, 1'b0);
        endTest("busy and reset", errorsBefore);

        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: convEngine_asserts.sv
////////////////////////////////////////////////////////////////////////////
// convEngineAsserts: concurrent checks on the result strobe, busy release
// and start-to-result latency, bound into convEngine
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module convEngineAsserts (
    input logic Clk,
    input logic arstN,
    input logic start,
    input logic busy,
    input logic resultValid
);

    // Result strobe lasts one cycle
    resultPulse: assert property (@(posedge Clk) disable iff (!arstN)
        resultValid |=> !busy || !resultValid)
        else $error("resultValid high for more than one cycle");

    // busy ends right after the result even with a start during the run
    busyRelease: assert property (@(posedge Clk) disable iff (!arstN)
        resultValid |=> !busy)
        else $error("busy still high after resultValid");

    // Accepted start seen 21 edges before the result is sampled
    resultLatency: assert property (@(posedge Clk) disable iff (!arstN)
        resultValid |-> $past(start && !busy, 21))
        else $error("resultValid without an accepted start 20 cycles earlier");

endmodule

bind convEngine convEngineAsserts asserts_i (
    .Clk         (Clk),
    .arstN       (arstN),
    .start       (start),
    .busy        (busy),
    .resultValid (resultValid)
);

// File: convPkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, lane count and multiplier timing for the convolution
// engine, plus the typedefs and the multiplier FSM state enum
////////////////////////////////////////////////////////////////////////////

package convPkg;

    // Kernel geometry
    localparam int kernelSize = 3;
    localparam int laneCount = kernelSize * kernelSize;
    localparam int xbarPoints = laneCount * laneCount;

    // Operand and product widths
    localparam int dataWidth = 16;
    localparam int productWidth = 2 * dataWidth;

    // One shift-add iteration per multiplier bit
    localparam int mulCycles = dataWidth;

    typedef logic signed [dataWidth-1:0] dataT;
    typedef logic signed [productWidth-1:0] productT;
    // Wraps modulo 2^32
    typedef logic signed [31:0] sumT;
    typedef logic [laneCount-1:0] laneMaskT;
    // Output index times laneCount plus input index
    typedef logic [6:0] xbarAddrT;
    typedef logic [$clog2(laneCount)-1:0] laneIdxT;
    typedef logic [$clog2(mulCycles)-1:0] mulCountT;

    typedef enum logic [1:0] {
        idle,
        run,
        finish
    } mulStateT;

endpackage

// File: laneIf.sv
////////////////////////////////////////////////////////////////////////////
// laneIf interface for one multiplier lane, with loader, multiplier
// and reducer modports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface laneIf ();

    // Operands, held stable by the loader for the whole operation
    convPkg::dataT a;
    convPkg::dataT b;
    // One-cycle pulse
    logic start;

    // Valid only while done is high
    convPkg::productT product;
    logic done;

    modport loader (
        output a, b, start
    );

    modport mult (
        input a, b, start,
        output product, done
    );

    modport reducer (
        input product, done
    );

endinterface

// File: operandLoader.sv
////////////////////////////////////////////////////////////////////////////
// operandLoader: captures operands and lane mask on an accepted start,
// pulses the lane starts and tracks busy until the reducer is done
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module operandLoader (
    input  logic              Clk,
    input  logic              arstN,
    input  logic              start,
    input  convPkg::laneMaskT laneMask,
    input  convPkg::dataT     opA [convPkg::laneCount],
    input  convPkg::dataT     opB [convPkg::laneCount],
    laneIf.loader             lanes [convPkg::laneCount],
    output convPkg::laneMaskT activeMask,
    output logic              busy,
    input  logic              opDone
);

    convPkg::dataT aReg [convPkg::laneCount];
    convPkg::dataT bReg [convPkg::laneCount];
    convPkg::laneMaskT startReg;
    logic accept;

    // Starts during an operation are dropped
    assign accept = start && !busy;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
            activeMask <= '0;
            startReg <= '0;
        end else begin
            startReg <= '0;
            if (accept) begin
                busy <= 1'b1;
                activeMask <= laneMask;
                // An empty mask still needs a timing reference for the reducer,
                // so lane 0 runs as a pilot and its product is zeroed downstream
                if (laneMask == '0) begin
                    startReg <= convPkg::laneMaskT'(1);
                end else begin
                    startReg <= laneMask;
                end
            end else if (opDone) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            aReg <= opA;
            bReg <= opB;
        end
    end

    for (genvar i = 0; i < convPkg::laneCount; i++) begin : genLane
        assign lanes[i].a = aReg[i];
        assign lanes[i].b = bReg[i];
        assign lanes[i].start = startReg[i];
    end

endmodule

// File: productReducer.sv
////////////////////////////////////////////////////////////////////////////
// productReducer: routing table, registered crossbar over the lane
// products and registered adder tree giving result and resultValid
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module productReducer (
    input  logic              Clk,
    input  logic              arstN,
    laneIf.reducer            lanes [convPkg::laneCount],
    input  convPkg::laneMaskT activeMask,
    input  logic              cfgWrite,
    input  convPkg::xbarAddrT cfgAddr,
    input  logic              direct,
    output convPkg::sumT      result,
    output logic              resultValid,
    output logic              opDone
);

    convPkg::productT maskedProduct [convPkg::laneCount];
    convPkg::laneMaskT laneDone;
    logic capture;

    // route[o] is the input lane feeding crossbar output o
    convPkg::laneIdxT route [convPkg::laneCount];
    convPkg::laneIdxT src [convPkg::laneCount];

    convPkg::productT routed [convPkg::laneCount];
    logic routedValid;
    convPkg::sumT treeSum;

    // Masked lanes contribute zero
    for (genvar i = 0; i < convPkg::laneCount; i++) begin : genLane
        assign laneDone[i] = lanes[i].done;
        assign maskedProduct[i] = activeMask[i] ? lanes[i].product : '0;
    end

    // All started lanes finish on the same cycle
    assign capture = |laneDone;

    // Routing table, identity after reset
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int o = 0; o < convPkg::laneCount; o++) begin
                route[o] <= convPkg::laneIdxT'(o);
            end
        end else if (cfgWrite && int'(cfgAddr) < convPkg::xbarPoints) begin
            route[int'(cfgAddr) / convPkg::laneCount] <=
                convPkg::laneIdxT'(int'(cfgAddr) % convPkg::laneCount);
        end
    end

    // Direct mode bypasses the table
    always_comb begin
        for (int o = 0; o < convPkg::laneCount; o++) begin
            if (direct) begin
                src[o] = convPkg::laneIdxT'(o);
            end else begin
                src[o] = route[o];
            end
        end
    end

    // Crossbar register
    always_ff @(posedge Clk) begin
        if (capture) begin
            for (int o = 0; o < convPkg::laneCount; o++) begin
                routed[o] <= maskedProduct[src[o]];
            end
        end
    end

    // Adder tree over the routed products
    always_comb begin
        treeSum = '0;
        for (int o = 0; o < convPkg::laneCount; o++) begin
            treeSum = treeSum + convPkg::sumT'(routed[o]);
        end
    end

    // Sum register and valid pipeline
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            routedValid <= 1'b0;
            resultValid <= 1'b0;
            result <= '0;
        end else begin
            routedValid <= capture;
            resultValid <= routedValid;
            if (routedValid) begin
                result <= treeSum;
            end
        end
    end

    // Loader releases busy on the same pulse
    assign opDone = resultValid;

endmodule

// File: seqMultiplier.sv
////////////////////////////////////////////////////////////////////////////
// seqMultiplier: radix-2 signed shift-add multiplier for one lane,
// mulCycles iterations followed by a finish cycle that pulses done
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module seqMultiplier (
    input logic  Clk,
    input logic  arstN,
    laneIf.mult  lane
);

    convPkg::mulStateT state;
    convPkg::mulCountT count;
    logic lastIter;
    logic doneReg;

    // Multiplicand moves left one place per iteration
    convPkg::productT mcand;
    // Multiplier bits consumed LSB first
    convPkg::dataT mplier;
    convPkg::productT acc;
    convPkg::productT productReg;
    convPkg::productT partial;

    assign lastIter = (count == convPkg::mulCountT'(convPkg::mulCycles - 1));

    // The top multiplier bit has negative weight in two's complement
    always_comb begin
        if (!mplier[0]) begin
            partial = '0;
        end else if (lastIter) begin
            partial = -mcand;
        end else begin
            partial = mcand;
        end
    end

    // FSM and iteration counter
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state <= convPkg::idle;
            count <= '0;
            doneReg <= 1'b0;
        end else begin
            doneReg <= 1'b0;
            case (state)
                convPkg::idle: begin
                    count <= '0;
                    if (lane.start) begin
                        state <= convPkg::run;
                    end
                end
                convPkg::run: begin
                    count <= count + 1'b1;
                    if (lastIter) begin
                        state <= convPkg::finish;
                    end
                end
                convPkg::finish: begin
                    doneReg <= 1'b1;
                    state <= convPkg::idle;
                end
                default: begin
                    state <= convPkg::idle;
                end
            endcase
        end
    end

    // Datapath
    always_ff @(posedge Clk) begin
        if (state == convPkg::idle && lane.start) begin
            mcand <= convPkg::productT'(lane.a);
            mplier <= lane.b;
            acc <= '0;
        end else if (state == convPkg::run) begin
            acc <= acc + partial;
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
        end
        if (state == convPkg::finish) begin
            productReg <= acc;
        end
    end

    assign lane.product = productReg;
    assign lane.done = doneReg;

endmodule
